// File: vlog.f
rtl/uart_pkg.sv
rtl/uart_if.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
bench/uart_slave_model.sv
bench/uart_cmd_tb.sv

// File: bench/uart_cmd_tb.sv
`timescale 1ns/10ps

module uart_cmd_tb;
  import uart_pkg::*;

  localparam int n_cmds     = 46;
  localparam int max_cycles = n_cmds * 300 + 1000;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_vld;
  logic [7:0]  read_data;
  logic        rsp_err;
  logic        inject;
  logic [7:0]  rsp_delay;
  int          frame_cnt;
  int          bad_cnt;
  logic [15:0] byte_hist;

  logic [7:0]  mirror [128];
  logic [8:0]  exp_q [$];                             // Err flag and data per open read.
  logic [8:0]  exp_rsp;
  string       cur_test;
  int          errors    = 0;
  int          test_errs = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          cycles    = 0;

  uart_cmd_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .rsp_err   (rsp_err)
  );

  uart_slave_model i_slave (
    .clk       (clk),
    .tx        (tx),
    .inject    (inject),
    .rsp_delay (rsp_delay),
    .rx        (rx),
    .frame_cnt (frame_cnt),
    .bad_cnt   (bad_cnt),
    .byte_hist (byte_hist)
  );

  always #10 clk = ~clk;

  function automatic logic [7:0] expected_read(input logic [6:0] addr);
    return mirror[addr];
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0)
      pass_cnt++;
    else
      fail_cnt++;
    $display("Test %s finished with %0d error(s)", cur_test, test_errs);
  endtask

  // Called at the drive point, 2 ns after a rising edge.
  task automatic send_cmd(input logic wr, input logic [6:0] addr, input logic [7:0] data);
    rsp_delay = 8'($urandom_range(0, 31));
    cmd_in    = {wr, addr, data};
    cmd_vld   = 1'b1;
    while (!cmd_rdy)
    begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
    if (wr)
      mirror[addr] = data;
    else
      exp_q.push_back({inject, expected_read(addr)});
  endtask

  task automatic wait_idle();
    do
    begin
      @(posedge clk);
      #2;
    end
    while (!cmd_rdy);
  endtask

  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Read response arrived with no read outstanding in test %s", cur_test);
        errors++;
        test_errs++;
      end
      else
      begin
        exp_rsp = exp_q.pop_front();
        check("read_data", exp_rsp[7:0], read_data);
        check("rsp_err", exp_rsp[8], rsp_err);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial
  begin
    int         fc;
    int         bc;
    int         low_cnt;
    logic       w;
    logic [6:0] a;
    logic [7:0] d;
    void'($urandom(32'h6ab785dd));
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    inject    = 1'b0;
    rsp_delay = '0;
    for (int i = 0; i < 128; i++)
      mirror[i] = 8'(i) ^ 8'hc3;                      // Matches the slave's power-up contents.
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_test("reset");
    check("tx", 1, tx);
    check("cmd_rdy", 1, cmd_rdy);
    check("read_vld", 0, read_vld);
    check("rsp_err", 0, rsp_err);
    end_test();

    start_test("write_frames");
    fc = frame_cnt;
    bc = bad_cnt;
    send_cmd(1'b1, 7'h15, 8'h3c);
    wait_idle();
    check("frame count", 2, frame_cnt - fc);
    check("hi and lo bytes", {1'b1, 7'h15, 8'h3c}, byte_hist);
    check("bad frames", 0, bad_cnt - bc);
    end_test();

    start_test("read_after_write");
    send_cmd(1'b1, 7'h2a, 8'h5c);
    wait_idle();
    fc = frame_cnt;
    send_cmd(1'b0, 7'h2a, 8'h00);
    wait_idle();
    check("read frames", 1, frame_cnt - fc);
    end_test();

    start_test("random_seq");
    repeat (40)
    begin
      w = 1'($urandom);
      a = 7'($urandom);
      d = 8'($urandom);
      send_cmd(w, a, d);
      wait_idle();
    end
    end_test();

    start_test("parity_err");
    inject = 1'b1;
    send_cmd(1'b0, 7'h2a, 8'h00);
    wait_idle();
    inject = 1'b0;
    send_cmd(1'b0, 7'h2a, 8'h00);
    wait_idle();
    end_test();

    start_test("held_vld");
    fc      = frame_cnt;
    cmd_in  = {1'b1, 7'h33, 8'ha9};
    cmd_vld = 1'b1;
    @(posedge clk);
    #2;
    low_cnt = 0;
    while (!cmd_rdy)
    begin
      low_cnt++;
      @(posedge clk);
      #2;
    end
    cmd_vld = 1'b0;
    mirror[7'h33] = 8'ha9;
    repeat (100) @(posedge clk);
    #2;
    check("frame count", 2, frame_cnt - fc);
    check("cmd_rdy low cycles", 2 * (1 + frame_bits * clk_per_bit) + gap_cycles, low_cnt);
    check("pending reads", 0, exp_q.size());
    end_test();

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: bench/uart_slave_model.sv
`timescale 1ns/10ps

module uart_slave_model (
  input  logic        clk,
  input  logic        tx,
  input  logic        inject,
  input  logic [7:0]  rsp_delay,
  output logic        rx,
  output int          frame_cnt,
  output int          bad_cnt,
  output logic [15:0] byte_hist
);
  import uart_pkg::*;

  logic [7:0] mem [128];
  uart_cmd_t  cmd;
  logic [7:0] rx_byte;

  // Sampled on the falling clock edge, mid-bit.
  task automatic get_frame(output logic [7:0] b);
    logic [9:0] bits;
    logic       start_ok;
    do @(negedge clk); while (tx !== start_bit);
    repeat (clk_per_bit / 2) @(negedge clk);
    start_ok = (tx == start_bit);
    for (int i = 0; i < 10; i++)
    begin
      repeat (clk_per_bit) @(negedge clk);
      bits[i] = tx;
    end
    b = bits[7:0];
    frame_cnt++;
    byte_hist = {byte_hist[7:0], b};
    if (!start_ok || ((^bits[8:0]) != 1'b1) || (bits[9] != stop_bit))
      bad_cnt++;                                      // Parity or framing problem.
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_par);
    logic [10:0] bits;
    bits = {stop_bit, (~^b) ^ bad_par, b, start_bit};
    @(posedge clk);
    #2;
    for (int i = 0; i < frame_bits; i++)
    begin
      rx = bits[i];
      repeat (clk_per_bit) @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    rx        = 1'b1;
    frame_cnt = 0;
    bad_cnt   = 0;
    byte_hist = '0;
    for (int a = 0; a < 128; a++)
      mem[a] = 8'(a) ^ 8'hc3;
    forever
    begin
      get_frame(rx_byte);
      cmd.b.hi = rx_byte;
      if (cmd.f.wr)
      begin
        get_frame(rx_byte);
        cmd.b.lo = rx_byte;
        mem[cmd.f.addr] = cmd.f.data;
      end
      else
      begin
        repeat (32 + rsp_delay) @(posedge clk);       // Leaves room for the gap and arm.
        send_frame(mem[cmd.f.addr], inject);
      end
    end
  end

endmodule

// File: rtl/uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  input  logic        rx,
  output logic        tx,
  output logic        read_vld,
  output logic [7:0]  read_data,
  output logic        rsp_err
);

  uart_byte_if byte_if ();
  uart_rsp_if  rsp_if ();

  uart_cmd_ctrl i_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .byte_if   (byte_if.ctrl),
    .rsp_if    (rsp_if.ctrl),
    .read_vld  (read_vld),
    .read_data (read_data),
    .rsp_err   (rsp_err)
  );

  uart_tx_frame i_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .byte_if (byte_if.phy),
    .tx      (tx)
  );

  uart_rx_frame i_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rsp_if (rsp_if.phy)
  );

endmodule

// File: rtl/uart_cmd_ctrl.sv
`timescale 1ns/10ps

module uart_cmd_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::uart_cmd_t cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  uart_byte_if.ctrl          byte_if,
  uart_rsp_if.ctrl           rsp_if,
  output logic               read_vld,
  output logic [7:0]         read_data,
  output logic               rsp_err
);
  import uart_pkg::*;

  logic [state_w-1:0] state;
  uart_cmd_t          cmd_q;
  logic [gap_w-1:0]   gap_cnt;
  logic               gap_end;

  assign cmd_rdy  = (state == st_idle);
  assign gap_end  = (gap_cnt == gap_w'(gap_cycles - 1));

  // Low byte only goes out in its own state.
  assign byte_if.data = (state == st_send_lo) ? cmd_q.b.lo : cmd_q.b.hi;

  // Response is passed straight through while a read is open.
  assign read_vld  = (state == st_wait_rsp) && rsp_if.vld;
  assign read_data = rsp_if.data;
  assign rsp_err   = read_vld && rsp_if.err;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      gap_cnt       <= '0;
      byte_if.start <= 1'b0;
      rsp_if.arm    <= 1'b0;
    end
    else
    begin
      byte_if.start <= 1'b0;
      rsp_if.arm    <= 1'b0;
      case (state)
        st_idle:
        begin
          if (cmd_vld)
          begin
            byte_if.start <= 1'b1;                    // Hi byte goes out for both kinds.
            state         <= st_send_hi;
          end
        end
        st_send_hi:
        begin
          if (byte_if.done)
          begin
            gap_cnt <= '0;
            state   <= st_gap;
          end
        end
        st_gap:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_end)
          begin
            if (cmd_q.f.wr)
            begin
              byte_if.start <= 1'b1;
              state         <= st_send_lo;
            end
            else
            begin
              rsp_if.arm <= 1'b1;
              state      <= st_wait_rsp;
            end
          end
        end
        st_send_lo:
        begin
          if (byte_if.done)
            state <= st_idle;
        end
        st_wait_rsp:
        begin
          if (rsp_if.vld)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  a_rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (byte_if.start || byte_if.busy || rsp_if.arm) |-> !cmd_rdy);

endmodule

// File: rtl/uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame (
  input logic      clk,
  input logic      rst_n,
  input logic      rx,
  uart_rsp_if.phy  rsp_if
);
  import uart_pkg::*;

  logic                 rx_s1;
  logic                 rx_s2;
  logic                 rx_q;                         // Previous synced value, for edges.
  logic                 fall;
  logic                 hunting;
  logic                 receiving;
  logic                 sample;
  logic [div_w-1:0]     div_cnt;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [7:0]           shreg;
  logic                 par_ok;

  assign fall        = rx_q & ~rx_s2;
  assign sample      = receiving && (div_cnt == '0);
  assign rsp_if.data = shreg;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_q  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_q  <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hunting    <= 1'b0;
      receiving  <= 1'b0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      rsp_if.vld <= 1'b0;
      rsp_if.err <= 1'b0;
    end
    else
    begin
      rsp_if.vld <= 1'b0;
      if (rsp_if.arm)
        hunting <= 1'b1;
      else if (hunting && fall)
      begin
        hunting   <= 1'b0;
        receiving <= 1'b1;
        div_cnt   <= div_w'(clk_per_bit / 2 - 1);     // First sample lands mid start bit.
        bit_cnt   <= '0;
      end
      else if (receiving)
      begin
        if (div_cnt != '0)
          div_cnt <= div_cnt - 1'b1;
        else
        begin
          div_cnt <= div_w'(clk_per_bit - 1);
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == '0 && rx_s2 != start_bit)
          begin
            receiving <= 1'b0;                        // Glitch, back to hunting.
            hunting   <= 1'b1;
          end
          if (bit_cnt == bit_cnt_w'(frame_bits - 1))
          begin
            receiving  <= 1'b0;
            rsp_if.vld <= 1'b1;
            rsp_if.err <= !par_ok || (rx_s2 != stop_bit);
          end
        end
      end
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_cnt >= bit_cnt_w'(1) && bit_cnt <= bit_cnt_w'(8))
        shreg <= {rx_s2, shreg[7:1]};
      if (bit_cnt == bit_cnt_w'(frame_bits - 2))
        par_ok <= ^{shreg, rx_s2};
    end
  end

  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_if.vld |=> !rsp_if.vld);

endmodule

// File: rtl/uart_tx_frame.sv
`timescale 1ns/10ps

module uart_tx_frame (
  input logic      clk,
  input logic      rst_n,
  uart_byte_if.phy byte_if,
  output logic     tx
);
  import uart_pkg::*;

  logic [div_w-1:0]     div_cnt;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [9:0]           shreg;                        // Data, parity and stop still to go.
  logic                 bit_end;
  logic                 last_bit;

  assign bit_end  = byte_if.busy && (div_cnt == div_w'(clk_per_bit - 1));
  assign last_bit = (bit_cnt == bit_cnt_w'(frame_bits - 1));

  assign byte_if.done = bit_end && last_bit;          // Last cycle of the stop bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      byte_if.busy <= 1'b0;
      tx           <= stop_bit;
      div_cnt      <= '0;
      bit_cnt      <= '0;
    end
    else if (byte_if.start)
    begin
      byte_if.busy <= 1'b1;
      tx           <= start_bit;
      div_cnt      <= '0;
      bit_cnt      <= '0;
    end
    else if (byte_if.busy)
    begin
      div_cnt <= div_cnt + 1'b1;
      if (bit_end)
      begin
        div_cnt <= '0;
        if (last_bit)
        begin
          byte_if.busy <= 1'b0;
          tx           <= stop_bit;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= shreg[0];
        end
      end
    end
  end

  // Odd parity: ones over data and parity bit come out odd.
  always_ff @(posedge clk)
  begin
    if (byte_if.start)
      shreg <= {stop_bit, ~^byte_if.data, byte_if.data};
    else if (bit_end && !last_bit)
      shreg <= {1'b1, shreg[9:1]};
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    byte_if.start |-> !byte_if.busy);

endmodule

// File: rtl/uart_if.sv
`timescale 1ns/10ps

interface uart_byte_if;
  logic       start;
  logic [7:0] data;
  logic       busy;
  logic       done;

  modport ctrl (output start, output data, input busy, input done);
  modport phy (input start, input data, output busy, output done);
endinterface

interface uart_rsp_if;
  logic       arm;
  logic       vld;
  logic [7:0] data;
  logic       err;

  modport ctrl (output arm, input vld, input data, input err);
  modport phy (input arm, output vld, output data, output err);
endinterface

// File: rtl/uart_pkg.sv
package uart_pkg;

  localparam int clk_per_bit = 8;                     // Clock cycles per serial bit.
  localparam int gap_cycles  = 16;                    // Idle cycles between frames.
  localparam int frame_bits  = 11;                    // Start, 8 data, parity, stop.
  localparam int bit_cnt_w   = 4;

  localparam int div_w = $clog2(clk_per_bit);
  localparam int gap_w = $clog2(gap_cycles);

  localparam logic start_bit = 1'b0;
  localparam logic stop_bit  = 1'b1;

  // Command sequencer states.
  localparam int state_w = 3;
  localparam logic [state_w-1:0] st_idle     = 3'd0;
  localparam logic [state_w-1:0] st_send_hi  = 3'd1;
  localparam logic [state_w-1:0] st_gap      = 3'd2;
  localparam logic [state_w-1:0] st_send_lo  = 3'd3;
  localparam logic [state_w-1:0] st_wait_rsp = 3'd4;

  typedef struct packed {
    logic       wr;                                   // High for a write.
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_fields_t;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } uart_cmd_bytes_t;

  // Same 16-bit command word, seen as fields or as the two bytes on the wire.
  typedef union packed {
    uart_cmd_fields_t f;
    uart_cmd_bytes_t  b;
  } uart_cmd_t;

endpackage
